//--- hdl/riscvPkg.sv
`default_nettype none

package riscvPkg;

    // RV32I major opcodes handled by the decode stage
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

    // Immediate layout selector
    typedef enum logic [2:0] {
        immNone = 3'd0,
        immI    = 3'd1,
        immS    = 3'd2,
        immB    = 3'd3,
        immU    = 3'd4,
        immJ    = 3'd5
    } immSrcT;

    // Coarse ALU operation from the main decoder
    typedef enum logic [1:0] {
        aluOpAdd   = 2'd0,
        aluOpSub   = 2'd1,
        aluOpFunct = 2'd2
    } aluOpT;

    // Concrete ALU operation for the execute stage
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluControlT;

endpackage

`default_nettype wire

//--- hdl/mainDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module mainDecoder (
    input  logic [6:0]       op,
    output riscvPkg::immSrcT immSrc,
    output riscvPkg::aluOpT  aluOp,
    output logic             regWrite,
    output logic             aluSrc,
    output logic             memWrite,
    output logic             resultSrc,
    output logic             branch,
    output logic             pcOp,
    output logic             illegal
);

    always_comb begin
        // Everything off unless the opcode says otherwise
        immSrc    = riscvPkg::immNone;
        aluOp     = riscvPkg::aluOpAdd;
        regWrite  = 1'b0;
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        resultSrc = 1'b0;
        branch    = 1'b0;
        pcOp      = 1'b0;
        illegal   = 1'b0;

        case (op)
            // Load, address is rs1 + imm
            riscvPkg::opLoad: begin
                regWrite  = 1'b1;
                immSrc    = riscvPkg::immI;
                aluSrc    = 1'b1;
                resultSrc = 1'b1;
            end
            // Arithmetic with immediate
            riscvPkg::opImm: begin
                regWrite = 1'b1;
                immSrc   = riscvPkg::immI;
                aluSrc   = 1'b1;
                aluOp    = riscvPkg::aluOpFunct;
            end
            riscvPkg::opStore: begin
                immSrc   = riscvPkg::immS;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            // Register-register
            riscvPkg::opReg: begin
                regWrite = 1'b1;
                aluOp    = riscvPkg::aluOpFunct;
            end
            // Compare by subtraction
            riscvPkg::opBranch: begin
                immSrc = riscvPkg::immB;
                branch = 1'b1;
                aluOp  = riscvPkg::aluOpSub;
            end
            riscvPkg::opLui: begin
                regWrite = 1'b1;
                immSrc   = riscvPkg::immU;
                aluSrc   = 1'b1;
            end
            // Same as lui but relative to the PC
            riscvPkg::opAuipc: begin
                regWrite = 1'b1;
                immSrc   = riscvPkg::immU;
                aluSrc   = 1'b1;
                pcOp     = 1'b1;
            end
            riscvPkg::opJal: begin
                regWrite = 1'b1;
                immSrc   = riscvPkg::immJ;
                aluSrc   = 1'b1;
                branch   = 1'b1;
                pcOp     = 1'b1;
            end
            // Target is rs1 + imm; bit 30 of the offset must not turn this into a subtract
            riscvPkg::opJalr: begin
                regWrite = 1'b1;
                immSrc   = riscvPkg::immI;
                aluSrc   = 1'b1;
                pcOp     = 1'b1;
            end
            // System, fence, CSR and anything unknown
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/aluDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module aluDecoder (
    input  riscvPkg::aluOpT       aluOp,
    input  logic [2:0]            funct3,
    input  logic                  funct7b5,
    input  logic                  opb5,
    output riscvPkg::aluControlT  aluControl
);

    // Only R-type with funct7 bit 5 set subtracts, addi never does
    logic isSub;

    assign isSub = funct7b5 & opb5;

    always_comb begin
        case (aluOp)
            riscvPkg::aluOpAdd: aluControl = riscvPkg::aluAdd;
            riscvPkg::aluOpSub: aluControl = riscvPkg::aluSub;
            riscvPkg::aluOpFunct: begin
                case (funct3)
                    3'b000: aluControl = isSub ? riscvPkg::aluSub : riscvPkg::aluAdd;
                    3'b001: aluControl = riscvPkg::aluSll;
                    3'b010: aluControl = riscvPkg::aluSlt;
                    3'b011: aluControl = riscvPkg::aluSltu;
                    3'b100: aluControl = riscvPkg::aluXor;
                    // Shift right, arithmetic when funct7 bit 5 is set
                    3'b101: aluControl = funct7b5 ? riscvPkg::aluSra : riscvPkg::aluSrl;
                    3'b110: aluControl = riscvPkg::aluOr;
                    default: aluControl = riscvPkg::aluAnd;
                endcase
            end
            default: aluControl = riscvPkg::aluAdd;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/immGenerator.sv
`timescale 1ns/10ps
`default_nettype none

module immGenerator #(
    parameter int dataWidth = 32
) (
    input  logic [31:0]          instr,
    input  riscvPkg::immSrcT     immSrc,
    output logic [dataWidth-1:0] imm
);

    logic [31:0] imm32;

    always_comb begin
        case (immSrc)
            riscvPkg::immI: imm32 = {{20{instr[31]}}, instr[31:20]};
            riscvPkg::immS: imm32 = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offset is in halfwords
            riscvPkg::immB: begin
                imm32 = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            riscvPkg::immU: imm32 = {instr[31:12], 12'h000};
            riscvPkg::immJ: begin
                imm32 = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm32 = 32'h0000_0000;
        endcase
    end

    // Sign extend to the datapath width
    assign imm = dataWidth'($signed(imm32));

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage #(
    parameter int dataWidth = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           instr,
    input  logic                  instrValid,
    input  logic                  stall,
    output logic                  outValid,
    output logic                  regWrite,
    output logic                  aluSrc,
    output logic                  memWrite,
    output logic                  resultSrc,
    output logic                  branch,
    output logic                  pcOp,
    output logic                  illegal,
    output riscvPkg::aluControlT  aluControl,
    output logic [dataWidth-1:0]  imm,
    output logic [4:0]            rd
);

    riscvPkg::immSrcT     immSrc;
    riscvPkg::aluOpT      aluOp;
    riscvPkg::aluControlT decAluControl;
    logic [dataWidth-1:0] decImm;
    logic                 decRegWrite;
    logic                 decAluSrc;
    logic                 decMemWrite;
    logic                 decResultSrc;
    logic                 decBranch;
    logic                 decPcOp;
    logic                 decIllegal;

    mainDecoder i_mainDecoder (
        .op        (instr[6:0]),
        .immSrc    (immSrc),
        .aluOp     (aluOp),
        .regWrite  (decRegWrite),
        .aluSrc    (decAluSrc),
        .memWrite  (decMemWrite),
        .resultSrc (decResultSrc),
        .branch    (decBranch),
        .pcOp      (decPcOp),
        .illegal   (decIllegal)
    );

    aluDecoder i_aluDecoder (
        .aluOp      (aluOp),
        .funct3     (instr[14:12]),
        .funct7b5   (instr[30]),
        .opb5       (instr[5]),
        .aluControl (decAluControl)
    );

    immGenerator #(
        .dataWidth (dataWidth)
    ) i_immGenerator (
        .instr  (instr),
        .immSrc (immSrc),
        .imm    (decImm)
    );

    // ID/EX control, a bubble clears every bit
    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            regWrite <= 1'b0;
            memWrite <= 1'b0;
            branch   <= 1'b0;
            pcOp     <= 1'b0;
            illegal  <= 1'b0;
        end else if (!stall) begin
            outValid <= instrValid;
            regWrite <= instrValid & decRegWrite;
            memWrite <= instrValid & decMemWrite;
            branch   <= instrValid & decBranch;
            pcOp     <= instrValid & decPcOp;
            illegal  <= instrValid & decIllegal;
        end
    end

    // ID/EX datapath side, held while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            aluSrc     <= instrValid & decAluSrc;
            resultSrc  <= instrValid & decResultSrc;
            aluControl <= decAluControl;
            imm        <= decImm;
            rd         <= instr[11:7];
        end
    end

endmodule

`default_nettype wire

//--- dv/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Release on a falling edge so the DUT sees a clean sample
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/decodeStage_assert.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStageAssert #(
    parameter int dataWidth = 32
) (
    input logic                 clk,
    input logic                 reset,
    input logic                 stall,
    input logic                 outValid,
    input logic                 regWrite,
    input logic                 aluSrc,
    input logic                 memWrite,
    input logic                 resultSrc,
    input logic                 branch,
    input logic                 pcOp,
    input logic                 illegal,
    input riscvPkg::aluControlT aluControl,
    input logic [dataWidth-1:0] imm,
    input logic [4:0]           rd
);

    // No instruction both writes a register and stores
    noRegAndMemWrite: assert property (@(posedge clk) disable iff (reset)
        outValid |-> !(regWrite && memWrite))
        else $error("regWrite and memWrite both high");

    // Stall holds the whole ID/EX register
    holdOnStall: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable({outValid, regWrite, aluSrc, memWrite, resultSrc, branch, pcOp,
                           illegal, aluControl, imm, rd}))
        else $error("outputs changed during stall");

    illegalNoControl: assert property (@(posedge clk) disable iff (reset)
        illegal |-> !(regWrite || memWrite || branch || pcOp))
        else $error("control bit high with illegal opcode");

    validLowAfterReset: assert property (@(posedge clk)
        reset |=> !outValid)
        else $error("outValid high after reset");

endmodule

bind decodeStage decodeStageAssert #(.dataWidth(dataWidth)) i_decodeStageAssert (.*);

`default_nettype wire

//--- dv/decodeStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb;

    localparam int dataWidth   = 32;
    localparam int resetCycles = 8;

    logic                 clk;
    logic                 reset;
    logic [31:0]          instr;
    logic                 instrValid;
    logic                 stall;
    logic                 outValid;
    logic                 regWrite;
    logic                 aluSrc;
    logic                 memWrite;
    logic                 resultSrc;
    logic                 branch;
    logic                 pcOp;
    logic                 illegal;
    riscvPkg::aluControlT aluControl;
    logic [dataWidth-1:0] imm;
    logic [4:0]           rd;

    // Vectors with control bits packed from regWrite down to illegal
    logic [31:0]          vecInstr[$];
    int                   vecStall[$];
    logic [3:0]           vecAlu[$];
    logic [31:0]          vecImm[$];
    logic [6:0]           vecCtrl[$];
    int                   maxStall;
    logic                 loaded;
    integer               seed;

    // Expected state of the ID/EX register
    logic                 prevValid;
    logic [6:0]           prevCtrl;
    riscvPkg::aluControlT prevAlu;
    logic [dataWidth-1:0] prevImm;
    logic [4:0]           prevRd;

    clockGen #(.resetCycles(resetCycles)) i_clockGen (
        .clk   (clk),
        .reset (reset)
    );

    decodeStage #(.dataWidth(dataWidth)) i_decodeStage (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .outValid   (outValid),
        .regWrite   (regWrite),
        .aluSrc     (aluSrc),
        .memWrite   (memWrite),
        .resultSrc  (resultSrc),
        .branch     (branch),
        .pcOp       (pcOp),
        .illegal    (illegal),
        .aluControl (aluControl),
        .imm        (imm),
        .rd         (rd)
    );

    task automatic stopOnError();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkAlu(input riscvPkg::aluControlT expected,
                            input riscvPkg::aluControlT actual);
        if (actual !== expected) begin
            $display("ERROR time=%0t aluControl expected=%0d actual=%0d",
                     $time, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkImm(input logic [dataWidth-1:0] expected,
                            input logic [dataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR time=%0t imm expected=%h actual=%h", $time, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkRd(input logic [4:0] expected, input logic [4:0] actual);
        if (actual !== expected) begin
            $display("ERROR time=%0t rd expected=%0d actual=%0d", $time, expected, actual);
            stopOnError();
        end
    endtask

    // Compare every output against the tracked register state
    task automatic compareState();
        checkBit("outValid", prevValid, outValid);
        checkBit("regWrite", prevCtrl[6], regWrite);
        checkBit("aluSrc", prevCtrl[5], aluSrc);
        checkBit("memWrite", prevCtrl[4], memWrite);
        checkBit("resultSrc", prevCtrl[3], resultSrc);
        checkBit("branch", prevCtrl[2], branch);
        checkBit("pcOp", prevCtrl[1], pcOp);
        checkBit("illegal", prevCtrl[0], illegal);
        checkAlu(prevAlu, aluControl);
        checkImm(prevImm, imm);
        checkRd(prevRd, rd);
    endtask

    task automatic readVectors();
        int         fd;
        int         count;
        int         st;
        int         b[7];
        logic [31:0] ins;
        logic [3:0]  alu;
        logic [31:0] im;
        string       line;
        fd = $fopen("dv/decodeInput.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            stopOnError();
        end
        maxStall = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                count = $sscanf(line, "%h %d %h %h %d %d %d %d %d %d %d", ins, st, alu, im,
                                b[0], b[1], b[2], b[3], b[4], b[5], b[6]);
                if (count != 11) begin
                    $display("malformed line in the vector file: %s", line);
                    stopOnError();
                end
                vecInstr.push_back(ins);
                vecStall.push_back(st);
                vecAlu.push_back(alu);
                vecImm.push_back(im);
                vecCtrl.push_back({b[0][0], b[1][0], b[2][0], b[3][0], b[4][0], b[5][0],
                                   b[6][0]});
                if (st > maxStall) maxStall = st;
            end
        end
        $fclose(fd);
    endtask

    // Watchdog sized from the vector count
    initial begin
        wait (loaded);
        #((resetCycles + vecInstr.size() * (maxStall + 5)) * 8);
        $display("simulation did not finish before the watchdog expired");
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        int idle;
        instr      = 32'h0000_0013;
        instrValid = 1'b0;
        stall      = 1'b0;
        loaded     = 1'b0;
        seed       = 32'h2cbd6c4f;
        readVectors();
        loaded = 1'b1;

        // Reset is released on a falling clock edge
        @(negedge reset);
        checkBit("outValid", 1'b0, outValid);
        checkBit("regWrite", 1'b0, regWrite);
        checkBit("memWrite", 1'b0, memWrite);
        checkBit("branch", 1'b0, branch);
        checkBit("pcOp", 1'b0, pcOp);
        checkBit("illegal", 1'b0, illegal);

        for (int i = 0; i < vecInstr.size(); i++) begin
            instr      = vecInstr[i];
            instrValid = 1'b1;
            stall      = (vecStall[i] != 0);
            // Stalled cycles keep the last register contents
            for (int k = 0; k < vecStall[i]; k++) begin
                @(negedge clk);
                compareState();
            end
            stall = 1'b0;
            @(negedge clk);
            prevValid = 1'b1;
            prevCtrl  = vecCtrl[i];
            prevAlu   = riscvPkg::aluControlT'(vecAlu[i]);
            prevImm   = dataWidth'($signed(vecImm[i]));
            prevRd    = vecInstr[i][11:7];
            compareState();

            // Bubbles with instr held, so datapath fields stay put
            idle = $unsigned($random(seed)) % 4;
            for (int k = 0; k < idle; k++) begin
                instrValid = 1'b0;
                @(negedge clk);
                prevValid = 1'b0;
                prevCtrl  = 7'b0;
                compareState();
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/decodeInput.txt
# instr stall aluControl imm regWrite aluSrc memWrite resultSrc branch pcOp illegal
# hex, decimal stall count, aluControl code in hex, imm in hex, control bits 0 or 1
00500093 0 0 00000005 1 1 0 0 0 0 0
fff00113 0 0 ffffffff 1 1 0 0 0 0 0
002081b3 0 0 00000000 1 0 0 0 0 0 0
40208233 0 1 00000000 1 0 0 0 0 0 0
0020d2b3 1 6 00000000 1 0 0 0 0 0 0
4020d333 0 7 00000000 1 0 0 0 0 0 0
002093b3 0 2 00000000 1 0 0 0 0 0 0
0020a433 0 3 00000000 1 0 0 0 0 0 0
0020b4b3 0 4 00000000 1 0 0 0 0 0 0
0020c533 0 5 00000000 1 0 0 0 0 0 0
0020e5b3 0 8 00000000 1 0 0 0 0 0 0
0020f633 0 9 00000000 1 0 0 0 0 0 0
ffc0a683 0 0 fffffffc 1 1 0 1 0 0 0
0020a423 2 0 00000008 0 1 1 0 0 0 0
fe20a823 0 0 fffffff0 0 1 1 0 0 0 0
00208863 0 1 00000010 0 0 0 0 1 0 0
fe209ce3 0 1 fffffff8 0 0 0 0 1 0 0
12345737 0 0 12345000 1 1 0 0 0 0 0
abcde7b7 0 0 abcde000 1 1 0 0 0 0 0
80000817 1 0 80000000 1 1 0 0 0 1 0
00001897 0 0 00001000 1 1 0 0 0 1 0
001000ef 0 0 00000800 1 1 0 0 1 1 0
ffdff06f 0 0 fffffffc 1 1 0 0 1 1 0
400280e7 0 0 00000400 1 1 0 0 0 1 0
00000073 0 0 00000000 0 0 0 0 0 0 1
7ff08093 3 0 000007ff 1 1 0 0 0 0 0

//--- decodeStage.f
hdl/riscvPkg.sv
hdl/mainDecoder.sv
hdl/aluDecoder.sv
hdl/immGenerator.sv
hdl/decodeStage.sv
dv/clockGen.sv
dv/decodeStage_assert.sv
dv/decodeStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module decodeStageTb -f decodeStage.f -o decodeStageSim \
    && ./obj_dir/decodeStageSim | grep "TEST OK" \
    || { echo "simulation failed"; exit 1; }
